/* sources.f */
+incdir+tests
hw/ble_rx_pkg.sv
hw/uart_baud_tick.sv
hw/uart_byte_rx.sv
hw/hex_line_parser.sv
hw/credit_out_queue.sv
hw/ble_accel_rx_top.sv
tests/tb_ble_accel_rx.sv

/* tests/ble_uart_driver.svh */
// UART serializer tasks for single bits, bytes and terminated lines on the rx line

`ifndef BLE_UART_DRIVER_SVH
`define BLE_UART_DRIVER_SVH

// ****************************************
// bit and byte level
// ****************************************

// hold one level for a full bit time, changes on the falling edge
task automatic drive_bit(input logic level);
   @(negedge clk);
   rx = level;
   repeat (BIT_CLKS - 1) @(negedge clk);
endtask

// 8N1 frame, LSB first
// a low stop bit is followed by one idle bit so the next start edge is seen
task automatic send_byte(input logic [7:0] data, input bit stop_low);
   int i;
   drive_bit(1'b0);
   for (i = 0; i < 8; i++) begin
      drive_bit(data[i]);
   end
   drive_bit(!stop_low);
   if (stop_low) begin
      drive_bit(1'b1);
   end
endtask

// ****************************************
// line level
// ****************************************

// characters of the string, then the terminator
// the character at bad_idx gets a low stop bit, -1 sends all clean
task automatic send_line_bad_stop(input string line, input int bad_idx);
   int i;
   for (i = 0; i < line.len(); i++) begin
      send_byte(line[i], i == bad_idx);
   end
   send_byte(LINE_END, 1'b0);
endtask

task automatic send_line(input string line);
   send_line_bad_stop(line, -1);
endtask

`endif

/* tests/tb_ble_accel_rx.sv */
// Testbench for the accelerometer receive path with consumer model, reference and checker

`timescale 1ns/1ps

module tb_ble_accel_rx;
   import ble_rx_pkg::*;

   localparam int CLK_NS     = 4;
   localparam int BIT_CLKS   = 64;
   localparam int Q_DEPTH    = 4;
   localparam int N_CREDITS  = 2;
   localparam int WAIT_CLKS  = 4 * BIT_CLKS;
   localparam int SETTLE_CLKS = 20;

   // lines over all sections, worst case bytes per line incl. the extra idle bit
   localparam int PLANNED_LINES  = 3 + 20 + 5 + 9 + 10;
   localparam int MAX_LINE_BYTES = 11;
   localparam int MARGIN_NS      = 200000;
   localparam int WATCHDOG_NS    = PLANNED_LINES * MAX_LINE_BYTES * 10 * BIT_CLKS * CLK_NS +
                                   MARGIN_NS;

   logic   clk;
   logic   rst_n;
   logic   rx;
   logic   credit;
   logic   o_valid;
   value_t o_value;
   count_t o_frame_err_count;
   count_t o_drop_count;

   integer seed = 32'hef06416b;
   int     mismatches = 0;
   int     other_errors = 0;
   int     rx_total = 0;
   int     exp_total = 0;
   int     exp_frame_errs = 0;
   int     exp_drops = 0;
   int     owed = 0;
   bit     credits_on = 1'b0;
   value_t got_q[$];
   value_t exp_q[$];
   value_t cmp_got;
   value_t cmp_exp;

   `include "ble_uart_driver.svh"

   ble_accel_rx_top #(
      .DIVISOR     (11'd4),
      .QUEUE_DEPTH (Q_DEPTH),
      .CREDITS     (N_CREDITS)
   ) dut0 (
      .clk               (clk),
      .i_rst_n           (rst_n),
      .i_rx              (rx),
      .i_credit          (credit),
      .o_valid           (o_valid),
      .o_value           (o_value),
      .o_frame_err_count (o_frame_err_count),
      .o_drop_count      (o_drop_count)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   // ****************************************
   // checking helpers
   // ****************************************

   task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
         mismatches++;
      end
   endtask

   // expected reading of a line by the parsing rule, returns 0 for a bad line
   function automatic bit line_to_reading(input string line, output value_t value);
      int         i;
      int         digits;
      bit         bad;
      logic [7:0] c;
      int         nib;
      value  = '0;
      digits = 0;
      bad    = 1'b0;
      for (i = 0; i < line.len(); i++) begin
         c   = line[i];
         nib = -1;
         if (c >= "0" && c <= "9") nib = c - "0";
         if (c >= "A" && c <= "F") nib = c - "A" + 10;
         if (c >= "a" && c <= "f") nib = c - "a" + 10;
         if (nib < 0 || digits == DIGITS_PER_LINE) begin
            bad = 1'b1;
         end else begin
            value = value * 16 + nib;
            digits++;
         end
      end
      return !bad && digits == DIGITS_PER_LINE;
   endfunction

   // hex digit in random case
   function automatic logic [7:0] random_hex_char();
      int r;
      r = $random(seed) & 15;
      if (r < 10) return 8'(8'h30 + r);
      if ($random(seed) & 1) return 8'(8'h41 + r - 10);
      return 8'(8'h61 + r - 10);
   endfunction

   // kind 0 good, 1 seven digits, 2 nine digits, 3 non-hex character, 4 empty
   function automatic string make_line(input int kind);
      string s;
      string junk;
      int    n;
      int    i;
      s    = "";
      junk = "gGxz :.-";
      case (kind)
         1:       n = 7;
         2:       n = 9;
         4:       n = 0;
         default: n = 8;
      endcase
      for (i = 0; i < n; i++) begin
         s = $sformatf("%s%c", s, random_hex_char());
      end
      if (kind == 3) begin
         s.putc(($random(seed) & 32'h7fff) % 8, junk[($random(seed) & 32'h7fff) % 8]);
      end
      return s;
   endfunction

   // book the expected outcome, then send the line
   task automatic run_line(input string line, input bit expect_drop);
      value_t v;
      bit     ok;
      ok = line_to_reading(line, v);
      if (!ok) begin
         exp_frame_errs++;
      end else if (expect_drop) begin
         exp_drops++;
      end else begin
         exp_q.push_back(v);
         exp_total++;
      end
      send_line(line);
   endtask

   task automatic wait_readings(input int n);
      int waited;
      waited = 0;
      while (rx_total < n && waited < WAIT_CLKS) begin
         @(posedge clk);
         waited++;
      end
      if (rx_total < n) begin
         $display("Error at %0t: only %0d of %0d readings arrived", $time, rx_total, n);
         other_errors++;
      end
      repeat (SETTLE_CLKS) @(posedge clk);
      check_equal(rx_total, n, "reading count");
   endtask

   task automatic check_counts();
      @(negedge clk);
      check_equal(o_frame_err_count, exp_frame_errs, "frame error count");
      check_equal(o_drop_count, exp_drops, "drop count");
   endtask

   task automatic set_credits(input bit on);
      @(posedge clk);
      credits_on = on;
   endtask

   // ****************************************
   // consumer and comparison
   // ****************************************

   // takes every reading, returns one credit per cycle while allowed
   always @(negedge clk) begin
      if (!rst_n) begin
         credit = 1'b0;
      end else begin
         if (o_valid) begin
            got_q.push_back(o_value);
            rx_total++;
            owed++;
         end
         if (credits_on && owed > 0) begin
            credit = 1'b1;
            owed--;
         end else begin
            credit = 1'b0;
         end
      end
   end

   always @(posedge clk) begin
      while (got_q.size() != 0) begin
         cmp_got = got_q.pop_front();
         if (exp_q.size() == 0) begin
            $display("Error at %0t: reading %h arrived with none expected", $time, cmp_got);
            other_errors++;
         end else begin
            cmp_exp = exp_q.pop_front();
            check_equal(cmp_got, cmp_exp, "reading value");
         end
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Error: run timed out at %0t before all tests finished", $time);
      $display("Test FAILED");
      $finish;
   end

   // ****************************************
   // stimulus
   // ****************************************

   initial begin
      int held_base;
      int i;
      rst_n  = 1'b0;
      rx     = 1'b1;
      credit = 1'b0;
      repeat (3) @(negedge clk);
      rst_n = 1'b1;

      // reset state, then no more than the initial credits go out
      @(negedge clk);
      check_equal(o_valid, 1'b0, "o_valid after reset");
      check_counts();
      for (i = 0; i < 3; i++) begin
         run_line(make_line(0), 1'b0);
      end
      wait_readings(N_CREDITS);
      set_credits(1'b1);
      wait_readings(exp_total);

      // random good lines with prompt credits
      for (i = 0; i < 20; i++) begin
         run_line(make_line(0), 1'b0);
      end
      wait_readings(exp_total);
      check_counts();

      // bad lines only
      for (i = 1; i <= 4; i++) begin
         run_line(make_line(i), 1'b0);
      end
      exp_frame_errs++;
      send_line_bad_stop(make_line(0), 3);
      wait_readings(exp_total);
      check_counts();

      // credits withheld, fill the queue, then overflow
      set_credits(1'b0);
      for (i = 0; i < N_CREDITS; i++) begin
         run_line(make_line(0), 1'b0);
      end
      wait_readings(exp_total);
      held_base = rx_total;
      for (i = 0; i < Q_DEPTH; i++) begin
         run_line(make_line(0), 1'b0);
      end
      for (i = 0; i < 3; i++) begin
         run_line(make_line(0), 1'b1);
      end
      repeat (SETTLE_CLKS) @(posedge clk);
      check_equal(rx_total, held_base, "readings sent without credit");
      check_counts();
      set_credits(1'b1);
      wait_readings(exp_total);

      // good and bad lines mixed
      for (i = 0; i < 10; i++) begin
         run_line(make_line(($random(seed) & 32'h7fff) % 5), 1'b0);
      end
      wait_readings(exp_total);
      check_counts();

      repeat (SETTLE_CLKS) @(posedge clk);
      if (exp_q.size() != 0) begin
         $display("Error: %0d expected readings were never delivered", exp_q.size());
         other_errors++;
      end
      $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

/* hw/ble_accel_rx_top.sv */
// Top level of the accelerometer receive path, UART in and credit-based reading out

`timescale 1ns/1ps

module ble_accel_rx_top #(
   parameter ble_rx_pkg::div_t DIVISOR     = 11'd27,
   parameter int               QUEUE_DEPTH = 4,
   parameter int               CREDITS     = 2
) (
   input  logic               clk,
   input  logic               i_rst_n,
   input  logic               i_rx,
   input  logic               i_credit,
   output logic               o_valid,
   output ble_rx_pkg::value_t o_value,
   output ble_rx_pkg::count_t o_frame_err_count,
   output ble_rx_pkg::count_t o_drop_count
);
   import ble_rx_pkg::*;

   logic     tick;
   logic     rx_byte_valid;
   rx_byte_s rx_byte;
   logic     word_valid;
   value_t   word;

   // ****************************************
   // input side
   // ****************************************

   uart_baud_tick #(
      .DIVISOR (DIVISOR)
   ) u_baud (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .o_tick  (tick)
   );

   uart_byte_rx u_rx (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_rx         (i_rx),
      .i_tick       (tick),
      .o_byte_valid (rx_byte_valid),
      .o_byte       (rx_byte)
   );

   // ****************************************
   // processing and output side
   // ****************************************

   hex_line_parser u_parser (
      .clk               (clk),
      .i_rst_n           (i_rst_n),
      .i_byte_valid      (rx_byte_valid),
      .i_byte            (rx_byte),
      .o_word_valid      (word_valid),
      .o_word            (word),
      .o_frame_err_count (o_frame_err_count)
   );

   credit_out_queue #(
      .QUEUE_DEPTH (QUEUE_DEPTH),
      .CREDITS     (CREDITS)
   ) u_queue (
      .clk          (clk),
      .i_rst_n      (i_rst_n),
      .i_word_valid (word_valid),
      .i_word       (word),
      .i_credit     (i_credit),
      .o_valid      (o_valid),
      .o_value      (o_value),
      .o_drop_count (o_drop_count)
   );

endmodule

/* hw/credit_out_queue.sv */
// Reading queue with credit counter, overflow drop counting and output

`timescale 1ns/1ps

module credit_out_queue #(
   parameter int QUEUE_DEPTH = 4,
   parameter int CREDITS     = 2
) (
   input  logic               clk,
   input  logic               i_rst_n,
   input  logic               i_word_valid,
   input  ble_rx_pkg::value_t i_word,
   input  logic               i_credit,
   output logic               o_valid,
   output ble_rx_pkg::value_t o_value,
   output ble_rx_pkg::count_t o_drop_count
);
   import ble_rx_pkg::*;

   localparam int PTR_W  = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int FILL_W = $clog2(QUEUE_DEPTH + 1);
   localparam int CRED_W = $clog2(CREDITS + 1);

   localparam logic [PTR_W-1:0]  LAST_SLOT = PTR_W'(QUEUE_DEPTH - 1);
   localparam logic [FILL_W-1:0] FULL_FILL = FILL_W'(QUEUE_DEPTH);

   value_t             mem [QUEUE_DEPTH];
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic [FILL_W-1:0]  fill;
   logic [CRED_W-1:0]  credit_cnt;
   logic               full;
   logic               pop;
   logic               push;
   logic               drop;

   assign full = (fill == FULL_FILL);

   // head goes out whenever the consumer has room
   assign pop  = (fill != '0) && (credit_cnt != '0);

   // a same-cycle pop frees the slot for the incoming word
   assign push = i_word_valid && (!full || pop);
   assign drop = i_word_valid && full && !pop;

   assign o_valid = pop;
   assign o_value = mem[rd_ptr];

   // ****************************************
   // pointers, fill level, credits
   // ****************************************

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         wr_ptr       <= '0;
         rd_ptr       <= '0;
         fill         <= '0;
         credit_cnt   <= CRED_W'(CREDITS);
         o_drop_count <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
         end

         case ({push, pop})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase

         // one credit back per reading taken
         case ({i_credit, pop})
            2'b10:   credit_cnt <= credit_cnt + 1'b1;
            2'b01:   credit_cnt <= credit_cnt - 1'b1;
            default: credit_cnt <= credit_cnt;
         endcase

         if (drop && o_drop_count != '1) begin
            o_drop_count <= o_drop_count + 1'b1;
         end
      end
   end

   // storage
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= i_word;
      end
   end

   a_credit_bound : assert property (@(posedge clk) disable iff (!i_rst_n)
      int'(credit_cnt) <= CREDITS)
      else $error("consumer returned more credits than it was given");

   a_send_needs_credit : assert property (@(posedge clk) disable iff (!i_rst_n)
      o_valid |-> (credit_cnt != '0))
      else $error("reading sent without a credit");

endmodule

/* hw/hex_line_parser.sv */
// Line framer and ASCII hex decoder with frame error counting

`timescale 1ns/1ps

module hex_line_parser (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  logic                 i_byte_valid,
   input  ble_rx_pkg::rx_byte_s i_byte,
   output logic                 o_word_valid,
   output ble_rx_pkg::value_t   o_word,
   output ble_rx_pkg::count_t   o_frame_err_count
);
   import ble_rx_pkg::*;

   localparam int               CNT_W    = $clog2(DIGITS_PER_LINE + 1);
   localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DIGITS_PER_LINE);

   value_t           word_acc;
   logic [CNT_W-1:0] digit_cnt;
   logic             line_bad;
   logic             is_hex;
   logic [3:0]       nibble;
   logic             is_end;
   logic             shift_en;
   logic             line_ok;

   // ****************************************
   // per-character decode
   // ****************************************

   always_comb begin
      is_hex = 1'b1;
      nibble = 4'h0;
      if (i_byte.data >= 8'h30 && i_byte.data <= 8'h39) begin
         // '0' .. '9'
         nibble = 4'(i_byte.data - 8'h30);
      end else if (i_byte.data >= 8'h41 && i_byte.data <= 8'h46) begin
         // 'A' .. 'F'
         nibble = 4'(i_byte.data - 8'h37);
      end else if (i_byte.data >= 8'h61 && i_byte.data <= 8'h66) begin
         // 'a' .. 'f'
         nibble = 4'(i_byte.data - 8'h57);
      end else begin
         is_hex = 1'b0;
      end
   end

   assign is_end = (i_byte.data == LINE_END);

   // a ninth digit is never shifted in
   assign shift_en = i_byte_valid && !is_end && is_hex && !i_byte.frame_err &&
                     (digit_cnt != FULL_CNT);

   // terminator itself must also arrive cleanly
   assign line_ok = !line_bad && !i_byte.frame_err && (digit_cnt == FULL_CNT);

   // ****************************************
   // line state and counters
   // ****************************************

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_word_valid      <= 1'b0;
         o_frame_err_count <= '0;
         digit_cnt         <= '0;
         line_bad          <= 1'b0;
      end else begin
         o_word_valid <= 1'b0;
         if (i_byte_valid) begin
            if (is_end) begin
               digit_cnt <= '0;
               line_bad  <= 1'b0;
               if (line_ok) begin
                  o_word_valid <= 1'b1;
               end else if (o_frame_err_count != '1) begin
                  o_frame_err_count <= o_frame_err_count + 1'b1;
               end
            end else if (shift_en) begin
               digit_cnt <= digit_cnt + 1'b1;
            end else begin
               line_bad <= 1'b1;
            end
         end
      end
   end

   // most significant digit first
   always_ff @(posedge clk) begin
      if (shift_en) begin
         word_acc <= {word_acc[$bits(value_t)-5:0], nibble};
      end
   end

   // accumulator is left alone on LINE_END and holds until the next byte
   assign o_word = word_acc;

endmodule

/* hw/uart_byte_rx.sv */
// Oversampled UART receiver FSM producing framed bytes

`timescale 1ns/1ps

module uart_byte_rx (
   input  logic                 clk,
   input  logic                 i_rst_n,
   input  logic                 i_rx,
   input  logic                 i_tick,
   output logic                 o_byte_valid,
   output ble_rx_pkg::rx_byte_s o_byte
);
   import ble_rx_pkg::*;

   // sample points in ticks, middle of start bit and full bit period
   localparam logic [3:0] MID_TICK  = 4'(OVERSAMPLE / 2 - 1);
   localparam logic [3:0] LAST_TICK = 4'(OVERSAMPLE - 1);

   rx_state_e  state;
   logic       rx_meta;
   logic       rx_sync;
   logic       rx_prev;
   logic [3:0] tick_cnt;
   logic [2:0] bit_cnt;
   byte_t      shift_reg;
   logic       sample_now;
   logic       start_edge;

   // falling edge on the synchronized line
   assign start_edge = rx_prev & ~rx_sync;

   // tick that lands on the current sample point
   always_comb begin
      if (state == START) begin
         sample_now = i_tick && (tick_cnt == MID_TICK);
      end else begin
         sample_now = i_tick && (tick_cnt == LAST_TICK);
      end
   end

   // ****************************************
   // control
   // ****************************************

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         rx_meta      <= 1'b1;
         rx_sync      <= 1'b1;
         rx_prev      <= 1'b1;
         state        <= IDLE;
         tick_cnt     <= '0;
         bit_cnt      <= '0;
         o_byte_valid <= 1'b0;
      end else begin
         // two-flop synchronizer, third flop for edge detect
         rx_meta      <= i_rx;
         rx_sync      <= rx_meta;
         rx_prev      <= rx_sync;
         o_byte_valid <= 1'b0;

         if (i_tick) begin
            tick_cnt <= sample_now ? 4'd0 : tick_cnt + 1'b1;
         end

         case (state)
            IDLE: begin
               if (start_edge) begin
                  state    <= START;
                  tick_cnt <= '0;
               end
            end
            START: begin
               // line back high at mid-bit means a glitch
               if (sample_now) begin
                  state   <= rx_sync ? IDLE : DATA;
                  bit_cnt <= '0;
               end
            end
            DATA: begin
               if (sample_now) begin
                  if (bit_cnt == 3'd7) begin
                     state <= STOP;
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end
            end
            STOP: begin
               if (sample_now) begin
                  state        <= IDLE;
                  o_byte_valid <= 1'b1;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // ****************************************
   // data path
   // ****************************************

   always_ff @(posedge clk) begin
      // LSB arrives first
      if (state == DATA && sample_now) begin
         shift_reg <= {rx_sync, shift_reg[7:1]};
      end
      if (state == STOP && sample_now) begin
         o_byte.data      <= shift_reg;
         o_byte.frame_err <= ~rx_sync;
      end
   end

   a_byte_pulse : assert property (@(posedge clk) disable iff (!i_rst_n)
      o_byte_valid |=> !o_byte_valid)
      else $error("byte valid held longer than one cycle");

endmodule

/* hw/uart_baud_tick.sv */
// Baud divider producing the 16x oversampling tick

`timescale 1ns/1ps

module uart_baud_tick #(
   parameter ble_rx_pkg::div_t DIVISOR = 11'd27
) (
   input  logic clk,
   input  logic i_rst_n,
   output logic o_tick
);
   import ble_rx_pkg::*;

   div_t cnt;

   // down-counter, one tick per wrap
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         cnt    <= DIVISOR - 1'b1;
         o_tick <= 1'b0;
      end else begin
         o_tick <= (cnt == '0);
         if (cnt == '0) begin
            cnt <= DIVISOR - 1'b1;
         end else begin
            cnt <= cnt - 1'b1;
         end
      end
   end

   // a zero divisor would never wrap
   a_divisor_nonzero : assert property (@(posedge clk) DIVISOR > 0)
      else $error("baud divisor must be nonzero");

endmodule

/* hw/ble_rx_pkg.sv */
// Shared widths, typedefs, receiver state encoding, byte struct and fixed constants

package ble_rx_pkg;

   // ****************************************
   // widths that carry a meaning
   // ****************************************

   // one received character
   typedef logic [7:0]  byte_t;

   // one decoded accelerometer reading
   typedef logic [31:0] value_t;

   // saturating event counter
   typedef logic [7:0]  count_t;

   // baud divisor, same width as the SoC baud generator
   typedef logic [10:0] div_t;

   // framed byte from the UART receiver
   // frame_err set when the stop bit was sampled low
   typedef struct packed {
      byte_t data;
      logic  frame_err;
   } rx_byte_s;

   // receiver FSM
   typedef enum logic [1:0] {
      IDLE,
      START,
      DATA,
      STOP
   } rx_state_e;

   // ****************************************
   // fixed constants
   // ****************************************

   // ticks per bit, the receiver counts assume 16
   localparam int OVERSAMPLE = 16;

   // hex digits in one reading
   localparam int DIGITS_PER_LINE = 8;

   // line feed closes a line
   localparam byte_t LINE_END = 8'h0A;

endpackage
